// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;
	localparam int opW = 5;
	localparam int aluOpW = 5;
	localparam int shamtW = 5;
	localparam int immW = 17;
	localparam int targetW = 27;

	// opcode field, instr[31:27]
	localparam logic [opW-1:0] opAlu = 5'd0;
	localparam logic [opW-1:0] opJ = 5'd1;
	localparam logic [opW-1:0] opBne = 5'd2;
	localparam logic [opW-1:0] opJal = 5'd3;
	localparam logic [opW-1:0] opJr = 5'd4;
	localparam logic [opW-1:0] opAddi = 5'd5;
	localparam logic [opW-1:0] opBlt = 5'd6;
	localparam logic [opW-1:0] opSw = 5'd7;
	localparam logic [opW-1:0] opLw = 5'd8;

	// alu op field of R-type, instr[6:2]
	localparam logic [aluOpW-1:0] aluAdd = 5'd0;
	localparam logic [aluOpW-1:0] aluSub = 5'd1;
	localparam logic [aluOpW-1:0] aluAnd = 5'd2;
	localparam logic [aluOpW-1:0] aluOr = 5'd3;
	localparam logic [aluOpW-1:0] aluSll = 5'd4;
	localparam logic [aluOpW-1:0] aluSra = 5'd5;

	localparam logic [regAddrW-1:0] linkReg = 5'd31;

	// bypass source for an execute operand
	localparam logic [1:0] bypNone = 2'd0;
	localparam logic [1:0] bypM = 2'd1;
	localparam logic [1:0] bypW = 2'd2;

	typedef union packed {
		struct packed {
			logic [opW-1:0] opcode;
			logic [regAddrW-1:0] rd;
			logic [regAddrW-1:0] rs;
			logic [regAddrW-1:0] rt;
			logic [shamtW-1:0] shamt;
			logic [aluOpW-1:0] aluOp;
			logic [1:0] spare;
		} rType;
		struct packed {
			logic [opW-1:0] opcode;
			logic [regAddrW-1:0] rd;
			logic [regAddrW-1:0] rs;
			logic signed [immW-1:0] imm;
		} iType;
		struct packed {
			logic [opW-1:0] opcode;
			logic [targetW-1:0] target;
		} jType;
	} instrWord_t;

	// first source; stores, branches and jr read rd here
	function automatic logic [regAddrW-1:0] srcA(instrWord_t w);
		case (w.rType.opcode)
			opAlu: return w.rType.rs;
			opAddi, opLw: return w.iType.rs;
			opSw, opBne, opBlt, opJr: return w.iType.rd;
			default: return '0;
		endcase
	endfunction

	// second source, zero when the instruction has none
	function automatic logic [regAddrW-1:0] srcB(instrWord_t w);
		case (w.rType.opcode)
			opAlu: return w.rType.rt;
			opSw, opBne, opBlt: return w.iType.rs;
			default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
	input logic clock,
	input logic rstN,
	input logic [cpuPkg::regAddrW-1:0] rdAddrA,
	input logic [cpuPkg::regAddrW-1:0] rdAddrB,
	output logic [cpuPkg::xlen-1:0] rdDataA,
	output logic [cpuPkg::xlen-1:0] rdDataB,
	input logic [cpuPkg::regAddrW-1:0] wrAddr,
	input logic [cpuPkg::xlen-1:0] wrData,
	input logic wrEn
);
	import cpuPkg::*;

	localparam int depth = 1 << regAddrW;

	logic [xlen-1:0] regs [depth];
	logic wrLive;

	assign wrLive = wrEn && (wrAddr != '0); // r0 never written

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < depth; i++)
				regs[i] <= '0;
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through so writeback and decode share a cycle
	assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

	zeroReg: assert property (@(posedge clock) disable iff (!rstN)
		(rdAddrA != '0 || rdDataA == '0) && (rdAddrB != '0 || rdDataB == '0))
		else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

// ==== pipeControl.sv ====
`default_nettype none

module pipeControl (
	input logic clock,
	input logic rstN,
	input cpuPkg::instrWord_t dInstr,
	input logic [cpuPkg::regAddrW-1:0] xRd,
	input logic [cpuPkg::regAddrW-1:0] xRs1,
	input logic [cpuPkg::regAddrW-1:0] xRs2,
	input logic [cpuPkg::regAddrW-1:0] mRd,
	input logic [cpuPkg::regAddrW-1:0] wRd,
	input logic xRegWrite,
	input logic xIsLoad,
	input logic mRegWrite,
	input logic wRegWrite,
	input logic redirect,
	output logic stall,
	output logic flush,
	output logic [1:0] aSel,
	output logic [1:0] bSel,
	output logic storeSel
);
	import cpuPkg::*;

	logic [regAddrW-1:0] dSrcA, dSrcB;
	logic loadHitA, loadHitB;

	function automatic logic [1:0] pickBypass(
		input logic [regAddrW-1:0] src,
		input logic [regAddrW-1:0] memRd,
		input logic memWr,
		input logic [regAddrW-1:0] wbRd,
		input logic wbWr
	);
		if (src == '0)
			return bypNone;
		if (memWr && memRd == src) // newest value wins
			return bypM;
		if (wbWr && wbRd == src)
			return bypW;
		return bypNone;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// load-use hazard
	assign dSrcA = srcA(dInstr);
	assign dSrcB = srcB(dInstr);

	// store data is picked up from W in the memory cycle, so sw only waits on its base
	assign loadHitA = (dSrcA == xRd) && (dInstr.rType.opcode != opSw);
	assign loadHitB = dSrcB == xRd;

	assign flush = redirect;
	assign stall = xIsLoad && xRegWrite && (xRd != '0) && (loadHitA || loadHitB)
		&& !redirect;

	//////////////////////////////////////////////////////////////////////
	// operand bypass
	assign aSel = pickBypass(xRs1, mRd, mRegWrite, wRd, wRegWrite);
	assign bSel = pickBypass(xRs2, mRd, mRegWrite, wRd, wRegWrite);
	assign storeSel = aSel == bypM; // producer one ahead, finish it in memory

	stallOneCycle: assert property (@(posedge clock) disable iff (!rstN)
		stall |=> !stall)
		else $error("load-use stall held longer than one cycle");

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`default_nettype none

module fetchStage #(
	parameter logic [cpuPkg::xlen-1:0] resetPc = '0
) (
	input logic clock,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic redirect,
	input logic [cpuPkg::xlen-1:0] redirectPc,
	output logic [cpuPkg::xlen-1:0] instrAddr,
	input logic [cpuPkg::xlen-1:0] instr,
	output cpuPkg::instrWord_t dInstr,
	output logic [cpuPkg::xlen-1:0] dPc
);
	import cpuPkg::*;

	logic [xlen-1:0] pc, nextPc;

	assign instrAddr = pc;
	assign nextPc = redirect ? redirectPc : pc + 32'd1; // word addressed

	always_ff @(posedge clock) begin
		if (!rstN)
			pc <= resetPc;
		else if (redirect || !stall)
			pc <= nextPc;
	end

	// fetch/decode register, all-zero word is the bubble
	always_ff @(posedge clock) begin
		if (!rstN || flush)
			dInstr <= '0;
		else if (!stall)
			dInstr <= instr;
	end

	always_ff @(posedge clock) begin
		if (!stall)
			dPc <= pc;
	end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`default_nettype none

module decodeStage (
	input logic clock,
	input logic rstN,
	input logic stall,
	input logic flush,
	input cpuPkg::instrWord_t dInstr,
	input logic [cpuPkg::xlen-1:0] dPc,
	input logic [cpuPkg::regAddrW-1:0] wRd,
	input logic wRegWrite,
	input logic [cpuPkg::xlen-1:0] wData,
	output logic [cpuPkg::regAddrW-1:0] xRd,
	output logic [cpuPkg::regAddrW-1:0] xRs1,
	output logic [cpuPkg::regAddrW-1:0] xRs2,
	output logic xRegWrite,
	output logic xIsLoad,
	output logic xIsStore,
	output logic [cpuPkg::aluOpW-1:0] xAluOp,
	output logic [cpuPkg::shamtW-1:0] xShamt,
	output logic xUseImm,
	output logic xBranchNe,
	output logic xBranchLt,
	output logic xJump,
	output logic xJumpReg,
	output logic xLink,
	output logic [cpuPkg::xlen-1:0] xRegA,
	output logic [cpuPkg::xlen-1:0] xRegB,
	output logic [cpuPkg::xlen-1:0] xImm,
	output logic [cpuPkg::xlen-1:0] xTarget,
	output logic [cpuPkg::xlen-1:0] xPc
);
	import cpuPkg::*;

	logic [opW-1:0] op;
	logic isAlu, isAddi, isLw, isSw;
	logic isBne, isBlt, isJ, isJal, isJr;
	logic [regAddrW-1:0] rs1, rs2, dest;
	logic writesReg;
	logic [xlen-1:0] regA, regB, imm, target;

	assign op = dInstr.rType.opcode;
	assign isAlu = op == opAlu;
	assign isAddi = op == opAddi;
	assign isLw = op == opLw;
	assign isSw = op == opSw;
	assign isBne = op == opBne;
	assign isBlt = op == opBlt;
	assign isJ = op == opJ;
	assign isJal = op == opJal;
	assign isJr = op == opJr;

	assign rs1 = srcA(dInstr);
	assign rs2 = srcB(dInstr);
	assign dest = isJal ? linkReg : dInstr.iType.rd;
	assign writesReg = (isAlu || isAddi || isLw || isJal) && (dest != '0);

	assign imm = {{(xlen-immW){dInstr.iType.imm[immW-1]}}, dInstr.iType.imm};
	assign target = {dPc[xlen-1:targetW], dInstr.jType.target}; // upper pc bits kept

	regFile regs0 (
		.clock, .rstN,
		.rdAddrA(rs1), .rdAddrB(rs2), .rdDataA(regA), .rdDataB(regB),
		.wrAddr(wRd), .wrData(wData), .wrEn(wRegWrite)
	);

	//////////////////////////////////////////////////////////////////////
	// decode/execute register
	always_ff @(posedge clock) begin
		if (!rstN || stall || flush) begin // bubble
			xRd <= '0;
			xRs1 <= '0;
			xRs2 <= '0;
			xRegWrite <= 1'b0;
			xIsLoad <= 1'b0;
			xIsStore <= 1'b0;
			xBranchNe <= 1'b0;
			xBranchLt <= 1'b0;
			xJump <= 1'b0;
			xJumpReg <= 1'b0;
			xLink <= 1'b0;
		end else begin
			xRd <= dest;
			xRs1 <= rs1;
			xRs2 <= rs2;
			xRegWrite <= writesReg;
			xIsLoad <= isLw;
			xIsStore <= isSw;
			xBranchNe <= isBne;
			xBranchLt <= isBlt;
			xJump <= isJ || isJal;
			xJumpReg <= isJr;
			xLink <= isJal;
		end
	end

	always_ff @(posedge clock) begin
		xAluOp <= isAlu ? dInstr.rType.aluOp : aluAdd; // addi, lw, sw all add
		xShamt <= dInstr.rType.shamt;
		xUseImm <= isAddi || isLw || isSw;
		xRegA <= regA;
		xRegB <= regB;
		xImm <= imm;
		xTarget <= target;
		xPc <= dPc;
	end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none

module executeStage (
	input logic clock,
	input logic rstN,
	input logic [cpuPkg::regAddrW-1:0] xRd,
	input logic [cpuPkg::regAddrW-1:0] xRs1,
	input logic [cpuPkg::regAddrW-1:0] xRs2,
	input logic xRegWrite,
	input logic xIsLoad,
	input logic xIsStore,
	input logic [cpuPkg::aluOpW-1:0] xAluOp,
	input logic [cpuPkg::shamtW-1:0] xShamt,
	input logic xUseImm,
	input logic xBranchNe,
	input logic xBranchLt,
	input logic xJump,
	input logic xJumpReg,
	input logic xLink,
	input logic [cpuPkg::xlen-1:0] xRegA,
	input logic [cpuPkg::xlen-1:0] xRegB,
	input logic [cpuPkg::xlen-1:0] xImm,
	input logic [cpuPkg::xlen-1:0] xTarget,
	input logic [cpuPkg::xlen-1:0] xPc,
	input logic [1:0] aSel,
	input logic [1:0] bSel,
	input logic storeSel,
	input logic [cpuPkg::xlen-1:0] wData,
	output logic redirect,
	output logic [cpuPkg::xlen-1:0] redirectPc,
	output logic [cpuPkg::regAddrW-1:0] mRd,
	output logic mRegWrite,
	output logic mIsLoad,
	output logic mIsStore,
	output logic [cpuPkg::xlen-1:0] mResult,
	output logic [cpuPkg::xlen-1:0] mStoreData
);
	import cpuPkg::*;

	logic [xlen-1:0] opA, opB, aluA, aluB, aluOut;
	logic [xlen-1:0] pcPlusOne, branchPc, storeDataQ;
	logic rdNe, rdLt, taken;
	logic storeFwdQ;

	function automatic logic [xlen-1:0] bypass(
		input logic [1:0] sel,
		input logic [xlen-1:0] regVal,
		input logic [xlen-1:0] memVal,
		input logic [xlen-1:0] wbVal
	);
		case (sel)
			bypM: return memVal;
			bypW: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = bypass(aSel, xRegA, mResult, wData);
	assign opB = bypass(bSel, xRegB, mResult, wData);

	//////////////////////////////////////////////////////////////////////
	// alu
	assign aluA = xIsStore ? opB : opA; // sw base sits in the second source
	assign aluB = xUseImm ? xImm : opB;

	always_comb begin
		case (xAluOp)
			aluAdd: aluOut = aluA + aluB;
			aluSub: aluOut = aluA - aluB;
			aluAnd: aluOut = aluA & aluB;
			aluOr: aluOut = aluA | aluB;
			aluSll: aluOut = aluA << xShamt;
			aluSra: aluOut = $signed(aluA) >>> xShamt;
			default: aluOut = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// control transfer, resolved here
	assign rdNe = opA != opB;
	assign rdLt = $signed(opA) < $signed(opB); // rd < rs
	assign taken = (xBranchNe && rdNe) || (xBranchLt && rdLt);

	assign pcPlusOne = xPc + 32'd1;
	assign branchPc = pcPlusOne + xImm;

	assign redirect = taken || xJump || xJumpReg;
	assign redirectPc = taken ? branchPc : (xJumpReg ? opA : xTarget);

	// execute/memory register
	always_ff @(posedge clock) begin
		if (!rstN) begin
			mRd <= '0;
			mRegWrite <= 1'b0;
			mIsLoad <= 1'b0;
			mIsStore <= 1'b0;
			storeFwdQ <= 1'b0;
		end else begin
			mRd <= xRd;
			mRegWrite <= xRegWrite;
			mIsLoad <= xIsLoad;
			mIsStore <= xIsStore;
			storeFwdQ <= xIsStore && storeSel;
		end
	end

	always_ff @(posedge clock) begin
		mResult <= xLink ? pcPlusOne : aluOut; // jal links the return pc
		storeDataQ <= opA;
	end

	// WM bypass, producer has moved on to writeback
	assign mStoreData = storeFwdQ ? wData : storeDataQ;

	noBypassR0: assert property (@(posedge clock) disable iff (!rstN)
		(xRs1 != '0 || aSel == bypNone) && (xRs2 != '0 || bSel == bypNone))
		else $error("bypass selected for register 0");

endmodule

`default_nettype wire

// ==== memWbStage.sv ====
`default_nettype none

module memWbStage (
	input logic clock,
	input logic rstN,
	input logic [cpuPkg::regAddrW-1:0] mRd,
	input logic mRegWrite,
	input logic mIsLoad,
	input logic mIsStore,
	input logic [cpuPkg::xlen-1:0] mResult,
	input logic [cpuPkg::xlen-1:0] mStoreData,
	input logic [cpuPkg::xlen-1:0] memReadData,
	output logic [cpuPkg::xlen-1:0] memAddr,
	output logic [cpuPkg::xlen-1:0] memWriteData,
	output logic memWrite,
	output logic [cpuPkg::regAddrW-1:0] wRd,
	output logic wRegWrite,
	output logic [cpuPkg::xlen-1:0] wData
);
	import cpuPkg::*;

	logic wIsLoad;
	logic [xlen-1:0] wResult, wLoad;

	// data port, memory answers in the same cycle
	assign memAddr = mResult;
	assign memWriteData = mStoreData;
	assign memWrite = mIsStore;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wRd <= '0;
			wRegWrite <= 1'b0;
			wIsLoad <= 1'b0;
		end else begin
			wRd <= mRd;
			wRegWrite <= mRegWrite;
			wIsLoad <= mIsLoad;
		end
	end

	always_ff @(posedge clock) begin
		wResult <= mResult;
		wLoad <= memReadData;
	end

	assign wData = wIsLoad ? wLoad : wResult;

	storeNotLoad: assert property (@(posedge clock) disable iff (!rstN)
		!(memWrite && mIsLoad))
		else $error("store and load flagged on the same instruction");

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`default_nettype none

module cpuTop #(
	parameter logic [cpuPkg::xlen-1:0] resetPc = '0
) (
	input logic clock,
	input logic rstN,
	output logic [cpuPkg::xlen-1:0] instrAddr,
	input logic [cpuPkg::xlen-1:0] instr,
	output logic [cpuPkg::xlen-1:0] memAddr,
	output logic [cpuPkg::xlen-1:0] memWriteData,
	output logic memWrite,
	input logic [cpuPkg::xlen-1:0] memReadData
);
	import cpuPkg::*;

	logic stall, flush, storeSel, redirect;
	logic [1:0] aSel, bSel;
	logic [xlen-1:0] redirectPc;
	instrWord_t dInstr; // fetch/decode register contents
	logic [xlen-1:0] dPc;

	// decode/execute register
	logic [regAddrW-1:0] xRd, xRs1, xRs2;
	logic xRegWrite, xIsLoad, xIsStore, xUseImm;
	logic xBranchNe, xBranchLt, xJump, xJumpReg, xLink;
	logic [aluOpW-1:0] xAluOp;
	logic [shamtW-1:0] xShamt;
	logic [xlen-1:0] xRegA, xRegB, xImm, xTarget, xPc;

	// execute/memory and memory/writeback registers
	logic [regAddrW-1:0] mRd, wRd;
	logic mRegWrite, mIsLoad, mIsStore, wRegWrite;
	logic [xlen-1:0] mResult, mStoreData, wData;

	//////////////////////////////////////////////////////////////////////
	pipeControl ctrl0 (.clock, .rstN, .dInstr, .xRd, .xRs1, .xRs2, .mRd, .wRd,
		.xRegWrite, .xIsLoad, .mRegWrite, .wRegWrite, .redirect,
		.stall, .flush, .aSel, .bSel, .storeSel);

	fetchStage #(.resetPc(resetPc)) fetch0 (.clock, .rstN, .stall, .flush,
		.redirect, .redirectPc, .instrAddr, .instr, .dInstr, .dPc);

	decodeStage decode0 (.clock, .rstN, .stall, .flush, .dInstr, .dPc,
		.wRd, .wRegWrite, .wData,
		.xRd, .xRs1, .xRs2, .xRegWrite, .xIsLoad, .xIsStore, .xAluOp, .xShamt,
		.xUseImm, .xBranchNe, .xBranchLt, .xJump, .xJumpReg, .xLink,
		.xRegA, .xRegB, .xImm, .xTarget, .xPc);

	executeStage exec0 (.clock, .rstN,
		.xRd, .xRs1, .xRs2, .xRegWrite, .xIsLoad, .xIsStore, .xAluOp, .xShamt,
		.xUseImm, .xBranchNe, .xBranchLt, .xJump, .xJumpReg, .xLink,
		.xRegA, .xRegB, .xImm, .xTarget, .xPc,
		.aSel, .bSel, .storeSel, .wData,
		.redirect, .redirectPc, .mRd, .mRegWrite, .mIsLoad, .mIsStore,
		.mResult, .mStoreData);

	memWbStage memWb0 (.clock, .rstN, .mRd, .mRegWrite, .mIsLoad, .mIsStore,
		.mResult, .mStoreData, .memReadData,
		.memAddr, .memWriteData, .memWrite, .wRd, .wRegWrite, .wData);

endmodule

`default_nettype wire

// ==== cpuTb.sv ====
`default_nettype none

module cpuTb;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 8;
	localparam int quietCycles = 20; // no store allowed after the last expected one
	localparam int cyclesPerWord = 16;
	localparam int memWords = 256;
	localparam string stimFile = "cpuStimulus.txt";

	logic clock;
	logic rstN;
	logic [31:0] instrAddr, instr;
	logic [31:0] memAddr, memWriteData, memReadData;
	logic memWrite;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int progLen;
	int storeIdx;
	bit loaded;

	cpuTop #(.resetPc(32'd0)) dut0 (
		.clock, .rstN,
		.instrAddr, .instr,
		.memAddr, .memWriteData, .memWrite, .memReadData
	);

	always #(clkPeriod / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// memory models answer in the same cycle
	assign instr = (instrAddr < 32'(memWords)) ? imem[instrAddr[7:0]] : 32'h0;
	assign memReadData = dmem[memAddr[7:0]];

	always @(posedge clock) begin
		if (rstN && memWrite)
			dmem[memAddr[7:0]] <= memWriteData;
	end

	task automatic stopWithFailure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic loadStimulus();
		int fd;
		int n;
		string line;
		string rest;
		logic [7:0] tag;
		logic [31:0] a, b;
		for (int i = 0; i < memWords; i++) begin
			imem[8'(i)] = 32'h0; // all-zero word decodes as a nop
			dmem[8'(i)] = (32'(i) * 32'h9E3779B9) ^ 32'h5A5A0000;
		end
		fd = $fopen(stimFile, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", stimFile);
			stopWithFailure();
		end
		progLen = 0;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1) begin
				tag = line.getc(0);
				rest = line.substr(1, line.len() - 1);
				case (tag)
					"I": begin
						n = $sscanf(rest, "%h", a);
						imem[8'(progLen)] = a;
						progLen++;
					end
					"D": begin
						n = $sscanf(rest, "%h %h", a, b);
						dmem[a[7:0]] = b;
					end
					"S": begin
						n = $sscanf(rest, "%h %h", a, b);
						expAddr.push_back(a);
						expData.push_back(b);
					end
					default: ; // comment or blank line
				endcase
			end
		end
		$fclose(fd);
		if (progLen == 0 || expAddr.size() == 0) begin
			$display("the stimulus file holds no program or no expected stores");
			stopWithFailure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stores are checked in program order
	always @(posedge clock) begin
		if (!rstN) begin
			assert (memWrite !== 1'b1) else begin
				$display("FAILED at time %0t: store seen while in reset", $time);
				stopWithFailure();
			end
		end else begin
			assert (!$isunknown(memWrite)) else begin
				$display("FAILED at time %0t: memWrite is unknown", $time);
				stopWithFailure();
			end
			if (memWrite) begin
				assert (storeIdx < expAddr.size()) else begin
					$display("FAILED at time %0t: extra store of %h to %h",
						$time, memWriteData, memAddr);
					stopWithFailure();
				end
				assert (memAddr === expAddr[storeIdx] && memWriteData === expData[storeIdx])
				else begin
					$display("FAILED at time %0t: store %0d wrote %h to %h, expected %h to %h",
						$time, storeIdx, memWriteData, memAddr,
						expData[storeIdx], expAddr[storeIdx]);
					stopWithFailure();
				end
				storeIdx++;
			end
		end
	end

	initial begin
		rstN = 1'b0;
		clock = 1'b0;
		storeIdx = 0;
		loaded = 1'b0;
		loadStimulus();
		loaded = 1'b1;
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		assert (instrAddr === 32'd0) else begin
			$display("FAILED at time %0t: instrAddr is %h on the first cycle, expected 0",
				$time, instrAddr);
			stopWithFailure();
		end
		while (storeIdx < expAddr.size())
			@(negedge clock);
		repeat (quietCycles) @(negedge clock); // program sits in its self-jump
		$display("*** TEST PASSED ***");
		$finish;
	end

	// watchdog
	initial begin
		wait (loaded);
		repeat (resetCycles + progLen * cyclesPerWord) @(posedge clock);
		$display("timeout: only %0d of %0d expected stores seen after %0d cycles",
			storeIdx, expAddr.size(), progLen * cyclesPerWord);
		stopWithFailure();
	end

endmodule

`default_nettype wire

// ==== cpuStimulus.txt ====
# I <word>: program word, hex, in order from address 0
# D <addr> <data>: initial data word; S <addr> <data>: expected store, in program order
I 28400005 addi r1, r0, 5
I 2881FFFD addi r2, r0, -3
I 28C00F0F addi r3, r0, 0xf0f
I 290000FF addi r4, r0, 0xff
I 01422000 add r5, r1, r2
I 01822004 sub r6, r1, r2
I 01C64008 and r7, r3, r4
I 0206400C or r8, r3, r4
I 02420210 sll r9, r1, 4
I 02840094 sra r10, r2, 1
I 39400080 sw r5, 0x80(r0)
I 39800081
I 39C00082
I 3A000083
I 3A400084
I 3A800085
I 38800086 sw r2, 0x86(r0)
I 2AC00007 addi r11, r0, 7
I 0316B000 add r12, r11, r11
I 0358B004 sub r13, r12, r11
I 3B400087 sw r13, 0x87(r0)
I 039AC00C or r14, r13, r12
I 3B800088 sw r14, 0x88(r0)
I 2BC00090 addi r15, r0, 0x90
I 3B9E0000 sw r14, 0(r15)
I 2C000064 addi r16, r0, 100
I 2C400001 addi r17, r0, 1
I 3C000089 sw r16, 0x89(r0)
I 44800040 lw r18, 0x40(r0)
I 04E51000 add r19, r18, r17
I 3CC0008A sw r19, 0x8a(r0)
I 45000041 lw r20, 0x41(r0)
I 3D00008B sw r20, 0x8b(r0)
I 2D400123 addi r21, r0, 0x123
I 3D4000A0 sw r21, 0xa0(r0)
I 458000A0 lw r22, 0xa0(r0)
I 3D80008C sw r22, 0x8c(r0)
I 45C00042 lw r23, 0x42(r0)
I 3CEE0000 sw r19, 0(r23)
I 10440002 bne r1, r2, +2 taken
I 3840008D
I 3840008E
I 30820002 blt r2, r1, +2 taken
I 3840008D
I 3840008E
I 10420005 bne r1, r1, +5 not taken
I 38C0008F sw r3, 0x8f(r0)
I 30440005 blt r1, r2, +5 not taken
I 39000091 sw r4, 0x91(r0)
I 2E000003 addi r24, r0, 3
I 16000002 bne r24, r0, +2 taken
I 3840008D
I 3840008E
I 08000038 j 56
I 3840008D
I 3840008E
I 1800003B jal 59
I 3840008D
I 3840008E
I 3FC00092 sw r31, 0x92(r0)
I 2E400040 addi r25, r0, 64
I 26400000 jr r25
I 3840008D
I 3840008E
I 3E400093 sw r25, 0x93(r0)
I 08000041 j 65, self-jump
D 40 12345678
D 41 FFFFFF80
D 42 000000B0
S 80 00000002
S 81 00000008
S 82 0000000F
S 83 00000FFF
S 84 00000050
S 85 FFFFFFFE
S 86 FFFFFFFD
S 87 00000007
S 88 0000000F
S 90 0000000F
S 89 00000064
S 8A 12345679
S 8B FFFFFF80
S A0 00000123
S 8C 00000123
S B0 12345679
S 8F 00000F0F
S 91 000000FF
S 92 00000039
S 93 00000040

// ==== vlog.f ====
cpuPkg.sv
regFile.sv
pipeControl.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
cpuTop.sv
cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module cpuTb -f vlog.f -o cpuSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > "$log" 2>&1
status=$?
cat "$log"

if grep -F -q '*** TEST FAILED ***' "$log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
exit 0
